/* sim.f */
src/muldiv_pkg.sv
src/muldiv_multiplier.sv
src/muldiv_divider.sv
src/muldiv_ctrl.sv
src/muldiv_top.sv
tb/muldiv_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, a nonzero exit status also counts as failure
run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/muldiv_tb.sv */
// self-checking testbench for the rv32m multiply/divide unit
// expected values follow the riscv m extension rules, widths are fixed at 32
// stops at the first failed check, every wait gives up after 100 cycles

`default_nettype none

module muldiv_tb;

    logic                             aclk;
    logic                             aresetn;
    logic                             i_srst;
    logic                             i_valid;
    logic                             o_ready;
    logic [muldiv_pkg::OP_W-1:0]      i_op;
    logic [muldiv_pkg::XLEN-1:0]      i_rs1;
    logic [muldiv_pkg::XLEN-1:0]      i_rs2;
    logic                             o_valid;
    logic                             i_ready;
    logic [muldiv_pkg::XLEN-1:0]      o_result;
    logic                             o_zero_div;
    // zero, one, minus one, most negative, most positive
    logic [31:0]                      corner [5];

    muldiv_top i_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_srst     (i_srst),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_op       (i_op),
        .i_rs1      (i_rs1),
        .i_rs2      (i_rs2),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_result   (o_result),
        .o_zero_div (o_zero_div)
    );

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    //////////////////////////////////////////////////////////////////////
    // failure reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else
            report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                     name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // rv32 reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] expected_result(
        input logic [2:0]  op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        longint      da;
        longint      db;
        longint      sq;
        longint      sr;
        // rs1 is unsigned only for mulhu, rs2 signed only for mulh
        ea   = (op == muldiv_pkg::OP_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
        eb   = (op == muldiv_pkg::OP_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        prod = ea * eb;
        // 64-bit truncating division, min / -1 cannot overflow here
        da = {{32{a[31]}}, a};
        db = {{32{b[31]}}, b};
        sq = 0;
        sr = 0;
        if (b != 32'b0) begin
            sq = da / db;
            sr = da % db;
        end
        case (op)
            muldiv_pkg::OP_MUL:  return prod[31:0];
            muldiv_pkg::OP_DIV:  return (b == 32'b0) ? 32'hffffffff : sq[31:0];
            muldiv_pkg::OP_DIVU: return (b == 32'b0) ? 32'hffffffff : a / b;
            muldiv_pkg::OP_REM:  return (b == 32'b0) ? a : sr[31:0];
            muldiv_pkg::OP_REMU: return (b == 32'b0) ? a : a % b;
            // the three high-half products
            default:             return prod[63:32];
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one operation, request to result transfer
    //////////////////////////////////////////////////////////////////////

    task automatic run_operation(input logic [2:0] op, input logic [31:0] a,
                                 input logic [31:0] b, input int hold);
        int          lat;
        int          exp_lat;
        logic [31:0] exp_res;
        logic        exp_zd;
        logic [31:0] held;
        exp_res = expected_result(op, a, b);
        exp_zd  = op[2] & (b == 32'b0);
        if (!op[2]) begin
            exp_lat = 4;
        end else if (b == 32'b0) begin
            exp_lat = 3;
        end else begin
            exp_lat = muldiv_pkg::XLEN + 3;
        end
        lat = 0;
        while (!o_ready) begin
            @(negedge aclk);
            lat++;
            if (lat > 100) report_failure("o_ready stayed low, request never taken");
        end
        i_op    = op;
        i_rs1   = a;
        i_rs2   = b;
        i_valid = 1'b1;
        @(negedge aclk);
        i_valid = 1'b0;
        // accepted on the last rising edge
        assert (!o_ready) else report_failure("o_ready still high after acceptance");
        lat = 1;
        while (!o_valid) begin
            @(negedge aclk);
            lat++;
            if (lat > 100) report_failure("no result within 100 cycles");
        end
        assert (lat == exp_lat) else
            report_failure($sformatf("o_valid came %0d cycles after acceptance, expected %0d",
                                     lat, exp_lat));
        // back-pressure, everything must hold
        held = o_result;
        repeat (hold) begin
            @(negedge aclk);
            assert (o_valid && !o_ready) else
                report_failure("handshake changed while the receiver was not ready");
            check_equal("o_result", o_result, held);
        end
        check_equal("o_result", o_result, exp_res);
        check_equal("o_zero_div", 32'(o_zero_div), 32'(exp_zd));
        i_ready = 1'b1;
        @(negedge aclk);
        i_ready = 1'b0;
        assert (!o_valid && o_ready) else
            report_failure("o_valid or o_ready wrong after the result transfer");
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          op;
        int          i;
        int          j;
        int          cycles;
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h0ad05ef8));
        corner[0] = 32'h00000000;
        corner[1] = 32'h00000001;
        corner[2] = 32'hffffffff;
        corner[3] = 32'h80000000;
        corner[4] = 32'h7fffffff;
        aresetn = 1'b0;
        i_srst  = 1'b0;
        i_valid = 1'b0;
        i_op    = muldiv_pkg::OP_MUL;
        i_rs1   = '0;
        i_rs2   = '0;
        i_ready = 1'b0;
        repeat (16) begin
            @(negedge aclk);
            assert (!o_valid && !o_zero_div && !o_ready) else
                report_failure("outputs not idle during reset");
        end
        aresetn = 1'b1;
        // o_ready expected on the first edge after release
        cycles = 0;
        while (!o_ready) begin
            @(negedge aclk);
            cycles++;
            if (cycles > 100) report_failure("o_ready never rose after reset");
        end
        assert (cycles == 1 && !o_valid && !o_zero_div) else
            report_failure("wrong state on the first cycle after reset");

        // all multiplications on corner pairs
        for (op = 0; op < 4; op++) begin
            for (i = 0; i < 5; i++) begin
                for (j = 0; j < 5; j++) begin
                    run_operation(op[2:0], corner[i], corner[j], 0);
                end
            end
        end
        // random multiplications, short random back-pressure
        for (op = 0; op < 4; op++) begin
            repeat (20) run_operation(op[2:0], $urandom(), $urandom(), $urandom_range(3, 0));
        end
        // random divisions, wide and narrow divisors of both signs
        for (op = 4; op < 8; op++) begin
            for (i = 0; i < 10; i++) begin
                a = $urandom();
                b = $urandom();
                if (i[0]) b = {{20{b[31]}}, b[11:0]};
                if (b == 32'b0) b = 32'd3;
                run_operation(op[2:0], a, b, $urandom_range(3, 0));
            end
        end
        // zero divisor and signed overflow
        for (op = 4; op < 8; op++) begin
            for (i = 0; i < 5; i++) begin
                run_operation(op[2:0], corner[i], 32'b0, 1);
            end
            run_operation(op[2:0], 32'h80000000, 32'hffffffff, 0);
        end
        // long back-pressure on random operations
        repeat (12) begin
            op = $urandom_range(7, 0);
            run_operation(op[2:0], $urandom(), $urandom() | 32'h1, $urandom_range(12, 1));
        end

        // synchronous clear in the middle of a division
        assert (o_ready) else report_failure("unit not idle before the clear test");
        i_op    = muldiv_pkg::OP_DIV;
        i_rs1   = $urandom();
        i_rs2   = 32'd7;
        i_valid = 1'b1;
        @(negedge aclk);
        i_valid = 1'b0;
        repeat (10) @(negedge aclk);
        i_srst = 1'b1;
        @(negedge aclk);
        i_srst = 1'b0;
        assert (!o_valid && !o_ready) else report_failure("clear did not drop the handshake");
        @(negedge aclk);
        assert (o_ready && !o_valid) else
            report_failure("o_ready did not return one cycle after the clear");
        run_operation(muldiv_pkg::OP_REM, $urandom(), 32'hfffffff9, 2);
        run_operation(muldiv_pkg::OP_MULHSU, $urandom(), $urandom(), 0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* src/muldiv_top.sv */
// rv32m multiply/divide unit, one operation at a time
// latency from acceptance to o_valid is 4 for mul, xlen+3 for div,
// 3 for a division by zero

`default_nettype none

module muldiv_top (
    input  wire                               aclk,
    input  wire                               aresetn,
    input  wire                               i_srst,
    // request
    input  wire                               i_valid,
    output logic                              o_ready,
    input  wire  [muldiv_pkg::OP_W-1:0]       i_op,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_rs1,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_rs2,
    // result
    output logic                              o_valid,
    input  wire                               i_ready,
    output logic [muldiv_pkg::XLEN-1:0]       o_result,
    output logic                              o_zero_div
);

    // control to divider and back
    logic                              div_start;
    logic                              div_signed;
    logic [muldiv_pkg::XLEN-1:0]       div_dividend;
    logic [muldiv_pkg::XLEN-1:0]       div_divisor;
    logic                              div_done;
    logic [muldiv_pkg::XLEN-1:0]       div_quot;
    logic [muldiv_pkg::XLEN-1:0]       div_rem;
    logic                              div_zero;
    // control to multiplier and back
    logic                              mul_start;
    logic                              mul_a_signed;
    logic                              mul_b_signed;
    logic [muldiv_pkg::XLEN-1:0]       mul_a;
    logic [muldiv_pkg::XLEN-1:0]       mul_b;
    logic                              mul_done;
    logic [2*muldiv_pkg::XLEN-1:0]     mul_product;

    muldiv_ctrl u_ctrl (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_srst         (i_srst),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .i_op           (i_op),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .o_valid        (o_valid),
        .i_ready        (i_ready),
        .o_result       (o_result),
        .o_zero_div     (o_zero_div),
        .o_div_start    (div_start),
        .o_div_signed   (div_signed),
        .o_div_dividend (div_dividend),
        .o_div_divisor  (div_divisor),
        .i_div_done     (div_done),
        .i_div_quot     (div_quot),
        .i_div_rem      (div_rem),
        .i_div_zero     (div_zero),
        .o_mul_start    (mul_start),
        .o_mul_a_signed (mul_a_signed),
        .o_mul_b_signed (mul_b_signed),
        .o_mul_a        (mul_a),
        .o_mul_b        (mul_b),
        .i_mul_done     (mul_done),
        .i_mul_product  (mul_product)
    );

    muldiv_divider u_div (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_srst     (i_srst),
        .i_start    (div_start),
        .i_signed   (div_signed),
        .i_dividend (div_dividend),
        .i_divisor  (div_divisor),
        .o_done     (div_done),
        .o_quot     (div_quot),
        .o_rem      (div_rem),
        .o_zero_div (div_zero)
    );

    muldiv_multiplier u_mul (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_srst     (i_srst),
        .i_start    (mul_start),
        .i_a_signed (mul_a_signed),
        .i_b_signed (mul_b_signed),
        .i_a        (mul_a),
        .i_b        (mul_b),
        .o_done     (mul_done),
        .o_product  (mul_product)
    );

endmodule

`default_nettype wire

/* src/muldiv_ctrl.sv */
// handshake and sequencing for the multiply/divide unit
// one operation in flight, no new acceptance while a result is held
// start pulses follow acceptance by one cycle, o_valid follows done by one

`default_nettype none

module muldiv_ctrl (
    input  wire                               aclk,
    input  wire                               aresetn,
    input  wire                               i_srst,
    // request side
    input  wire                               i_valid,
    output logic                              o_ready,
    input  wire  [muldiv_pkg::OP_W-1:0]       i_op,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_rs1,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_rs2,
    // result side
    output logic                              o_valid,
    input  wire                               i_ready,
    output logic [muldiv_pkg::XLEN-1:0]       o_result,
    output logic                              o_zero_div,
    // divider
    output logic                              o_div_start,
    output logic                              o_div_signed,
    output logic [muldiv_pkg::XLEN-1:0]       o_div_dividend,
    output logic [muldiv_pkg::XLEN-1:0]       o_div_divisor,
    input  wire                               i_div_done,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_div_quot,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_div_rem,
    input  wire                               i_div_zero,
    // multiplier
    output logic                              o_mul_start,
    output logic                              o_mul_a_signed,
    output logic                              o_mul_b_signed,
    output logic [muldiv_pkg::XLEN-1:0]       o_mul_a,
    output logic [muldiv_pkg::XLEN-1:0]       o_mul_b,
    input  wire                               i_mul_done,
    input  wire  [2*muldiv_pkg::XLEN-1:0]     i_mul_product
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_HOLD
    } state_t;

    state_t                        state;
    logic                          start_q;
    logic [muldiv_pkg::OP_W-1:0]   op_q;
    logic [muldiv_pkg::XLEN-1:0]   rs1_q;
    logic [muldiv_pkg::XLEN-1:0]   rs2_q;
    logic                          accept;
    logic                          sel_div;
    logic                          sel_rem;
    logic                          sel_hi;
    logic                          unit_done;
    logic [muldiv_pkg::XLEN-1:0]   res_sel;

    // o_ready is only high in idle
    assign accept = i_valid & o_ready;

    //////////////////////////////////////////////////////////////////////
    // decode of the latched operation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_div        = 1'b0;
        sel_rem        = 1'b0;
        sel_hi         = 1'b0;
        o_mul_a_signed = 1'b0;
        o_mul_b_signed = 1'b0;
        o_div_signed   = 1'b0;
        case (op_q)
            muldiv_pkg::OP_MULH: begin
                sel_hi         = 1'b1;
                o_mul_a_signed = 1'b1;
                o_mul_b_signed = 1'b1;
            end
            muldiv_pkg::OP_MULHSU: begin
                sel_hi         = 1'b1;
                o_mul_a_signed = 1'b1;
            end
            muldiv_pkg::OP_MULHU: sel_hi = 1'b1;
            muldiv_pkg::OP_DIV: begin
                sel_div      = 1'b1;
                o_div_signed = 1'b1;
            end
            muldiv_pkg::OP_DIVU: sel_div = 1'b1;
            muldiv_pkg::OP_REM: begin
                sel_div      = 1'b1;
                sel_rem      = 1'b1;
                o_div_signed = 1'b1;
            end
            muldiv_pkg::OP_REMU: begin
                sel_div = 1'b1;
                sel_rem = 1'b1;
            end
            // OP_MUL: low half, signedness does not matter
            default: sel_hi = 1'b0;
        endcase
    end

    // one start pulse, steered to the selected unit
    assign o_div_start    = start_q & sel_div;
    assign o_mul_start    = start_q & ~sel_div;
    assign o_div_dividend = rs1_q;
    assign o_div_divisor  = rs2_q;
    assign o_mul_a        = rs1_q;
    assign o_mul_b        = rs2_q;

    assign unit_done = sel_div ? i_div_done : i_mul_done;

    // result mux
    always_comb begin
        if (sel_div) begin
            res_sel = sel_rem ? i_div_rem : i_div_quot;
        end else if (sel_hi) begin
            res_sel = i_mul_product[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN];
        end else begin
            res_sel = i_mul_product[muldiv_pkg::XLEN-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state      <= ST_IDLE;
            start_q    <= 1'b0;
            op_q       <= muldiv_pkg::OP_MUL;
            o_ready    <= 1'b0;
            o_valid    <= 1'b0;
            o_zero_div <= 1'b0;
        end else if (i_srst) begin
            state      <= ST_IDLE;
            start_q    <= 1'b0;
            op_q       <= muldiv_pkg::OP_MUL;
            o_ready    <= 1'b0;
            o_valid    <= 1'b0;
            o_zero_div <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    o_ready <= 1'b1;
                    if (accept) begin
                        o_ready <= 1'b0;
                        start_q <= 1'b1;
                        op_q    <= i_op;
                        state   <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // wait for the started unit
                    if (unit_done) begin
                        o_valid    <= 1'b1;
                        o_zero_div <= sel_div & i_div_zero;
                        state      <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // hold until the receiver takes it
                    if (i_ready) begin
                        o_valid    <= 1'b0;
                        o_zero_div <= 1'b0;
                        o_ready    <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operands and result
    always_ff @(posedge aclk) begin
        if (accept) begin
            rs1_q <= i_rs1;
            rs2_q <= i_rs2;
        end
        if (state == ST_BUSY && unit_done) begin
            o_result <= res_sel;
        end
    end

endmodule

`default_nettype wire

/* src/muldiv_divider.sv */
// iterative restoring divider, one quotient bit per cycle
// normal case done comes xlen+1 cycles after start, zero divisor after one
// i_start must only pulse while idle, outputs hold until the next start

`default_nettype none

module muldiv_divider (
    input  wire                               aclk,
    input  wire                               aresetn,
    input  wire                               i_srst,
    input  wire                               i_start,
    input  wire                               i_signed,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_dividend,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_divisor,
    output logic                              o_done,
    output logic [muldiv_pkg::XLEN-1:0]       o_quot,
    output logic [muldiv_pkg::XLEN-1:0]       o_rem,
    output logic                              o_zero_div
);

    logic                          busy;
    logic [muldiv_pkg::CNT_W-1:0]  cnt;
    logic                          last;
    logic                          div_zero;
    // partial remainder
    logic [muldiv_pkg::XLEN-1:0]   acc;
    // dividend bits shift out, quotient bits shift in
    logic [muldiv_pkg::XLEN-1:0]   q;
    logic [muldiv_pkg::XLEN-1:0]   divs_mag;
    logic                          quot_neg;
    logic                          rem_neg;
    logic [muldiv_pkg::XLEN:0]     shifted;
    logic [muldiv_pkg::XLEN:0]     diff;
    logic [muldiv_pkg::XLEN-1:0]   acc_nxt;
    logic [muldiv_pkg::XLEN-1:0]   q_nxt;

    // two's complement negate when en is set
    function automatic logic [muldiv_pkg::XLEN-1:0] cond_neg(
        input logic [muldiv_pkg::XLEN-1:0] v,
        input logic                        en
    );
        cond_neg = en ? (~v + 1'b1) : v;
    endfunction

    assign div_zero = (i_divisor == '0);
    assign last     = &cnt;

    //////////////////////////////////////////////////////////////////////
    // one restoring step
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        shifted = {acc, q[muldiv_pkg::XLEN-1]};
        diff    = shifted - {1'b0, divs_mag};
        // borrow set means the divisor did not fit
        if (diff[muldiv_pkg::XLEN]) begin
            acc_nxt = shifted[muldiv_pkg::XLEN-1:0];
        end else begin
            acc_nxt = diff[muldiv_pkg::XLEN-1:0];
        end
        q_nxt = {q[muldiv_pkg::XLEN-2:0], ~diff[muldiv_pkg::XLEN]};
    end

    //////////////////////////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            cnt        <= '0;
            o_done     <= 1'b0;
            o_zero_div <= 1'b0;
        end else if (i_srst) begin
            busy       <= 1'b0;
            cnt        <= '0;
            o_done     <= 1'b0;
            o_zero_div <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                // zero divisor finishes at once
                o_zero_div <= div_zero;
                o_done     <= div_zero;
                busy       <= ~div_zero;
                cnt        <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // datapath, load magnitudes then iterate
    always_ff @(posedge aclk) begin
        if (i_start) begin
            quot_neg <= i_signed & (i_dividend[muldiv_pkg::XLEN-1] ^ i_divisor[muldiv_pkg::XLEN-1]);
            rem_neg  <= i_signed & i_dividend[muldiv_pkg::XLEN-1];
            acc      <= '0;
            q        <= cond_neg(i_dividend, i_signed & i_dividend[muldiv_pkg::XLEN-1]);
            divs_mag <= cond_neg(i_divisor, i_signed & i_divisor[muldiv_pkg::XLEN-1]);
            if (div_zero) begin
                o_quot <= '1;
                o_rem  <= i_dividend;
            end
        end else if (busy) begin
            acc <= acc_nxt;
            q   <= q_nxt;
            // restore signs, also covers min / -1
            if (last) begin
                o_quot <= cond_neg(q_nxt, quot_neg);
                o_rem  <= cond_neg(acc_nxt, rem_neg);
            end
        end
    end

endmodule

`default_nettype wire

/* src/muldiv_multiplier.sv */
// two-stage multiplier, done comes exactly 2 cycles after start
// each operand is extended to xlen+1 bits by its own signed flag

`default_nettype none

module muldiv_multiplier (
    input  wire                               aclk,
    input  wire                               aresetn,
    input  wire                               i_srst,
    input  wire                               i_start,
    input  wire                               i_a_signed,
    input  wire                               i_b_signed,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_a,
    input  wire  [muldiv_pkg::XLEN-1:0]       i_b,
    output logic                              o_done,
    output logic [2*muldiv_pkg::XLEN-1:0]     o_product
);

    logic                              s1_vld;
    logic signed [muldiv_pkg::XLEN:0]  a_q;
    logic signed [muldiv_pkg::XLEN:0]  b_q;
    // full signed product, top two bits never needed
    logic signed [2*muldiv_pkg::XLEN+1:0] prod_full;

    assign prod_full = a_q * b_q;

    // valid pipe
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s1_vld <= 1'b0;
            o_done <= 1'b0;
        end else if (i_srst) begin
            s1_vld <= 1'b0;
            o_done <= 1'b0;
        end else begin
            s1_vld <= i_start;
            o_done <= s1_vld;
        end
    end

    // stage one, extended operands
    // stage two, product
    always_ff @(posedge aclk) begin
        if (i_start) begin
            a_q <= {i_a_signed & i_a[muldiv_pkg::XLEN-1], i_a};
            b_q <= {i_b_signed & i_b[muldiv_pkg::XLEN-1], i_b};
        end
        if (s1_vld) begin
            o_product <= prod_full[2*muldiv_pkg::XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/muldiv_pkg.sv */
// shared constants for the rv32m multiply/divide unit
// data width is fixed at 32, the rv64 word forms are not supported
// operation codes equal the instruction funct3 field

`default_nettype none

package muldiv_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // operand and result width
    localparam int XLEN  = 32;
    // divider step counter, log2 of xlen
    localparam int CNT_W = $clog2(XLEN);
    // operation code width
    localparam int OP_W  = 3;

    //////////////////////////////////////////////////////////////////////
    // operation codes (funct3)
    //////////////////////////////////////////////////////////////////////

    // multiplications, bit 2 clear
    localparam logic [OP_W-1:0] OP_MUL    = 3'd0;
    localparam logic [OP_W-1:0] OP_MULH   = 3'd1;
    localparam logic [OP_W-1:0] OP_MULHSU = 3'd2;
    localparam logic [OP_W-1:0] OP_MULHU  = 3'd3;
    // divisions, bit 2 set
    localparam logic [OP_W-1:0] OP_DIV    = 3'd4;
    localparam logic [OP_W-1:0] OP_DIVU   = 3'd5;
    localparam logic [OP_W-1:0] OP_REM    = 3'd6;
    localparam logic [OP_W-1:0] OP_REMU   = 3'd7;

endpackage

`default_nettype wire
